/* Makefile */
TOOL       = verilator
TOP        = main_glue_tb
RTL_TOP    = main_glue
FILELIST   = all.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --timescale 1ns/100ps -j 0
LINT_FLAGS = --lint-only --timing --timescale 1ns/100ps
PASS_MSG   = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
source/main_pkg.sv
source/cpu_bus_if.sv
source/addr_decoder.sv
source/read_mux.sv
source/dtack_gen.sv
source/vblank_irq.sv
source/main_glue.sv
sim/main_glue_tb.sv

/* sim/main_glue_tb.sv */
`timescale 1ns/100ps

module main_glue_tb;

    localparam int LINE_W       = 9;
    localparam int VBLANK_LINE  = 223;
    localparam int N_SWEEP      = 32;               // Every page and sub-page once
    localparam int N_RANDOM     = 64;
    localparam int MAX_WAIT     = 7;                // Longest ok-low stretch
    localparam int CYCLE_CLKS   = MAX_WAIT + 12;    // Worst bus cycle with overhead
    localparam int TIMEOUT_CLKS = (N_SWEEP + N_RANDOM + 40) * CYCLE_CLKS;

    logic                clk, rst, cpu_cen, cpu_cenb;
    main_pkg::cpu_addr_t addr;
    logic                as_n, rnw, uds_n, lds_n, bgack_n;
    logic [2:0]          fc;
    main_pkg::word_t     cpu_din;
    logic                dtack_n, ipl2_n, vpa_n, uds_wn, lds_wn;
    logic [LINE_W-1:0]   vdump;
    logic                hstart;
    logic                rom_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs, wdog_cs, ram_cs;
    main_pkg::rom_addr_t rom_addr;
    main_pkg::word_t     rom_data, ram_data, char_dout, pal_dout, obj_dout;
    logic                rom_ok, ram_ok;

    main_pkg::sel_t      dut_sel;
    logic [31:0]         rng;
    main_pkg::rom_addr_t exp_rom;     // Last ROM word address seen on the bus

    // Bit order follows the SEL_* positions
    assign dut_sel = {ram_cs, wdog_cs, io_cs, pal_cs, objram_cs, char_cs, vram_cs, rom_cs};

    main_glue #(
        .LINE_W      (LINE_W),
        .VBLANK_LINE (VBLANK_LINE)
    ) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // CPU clock enables on alternate clocks
    initial begin
        cpu_cen  <= 1'b1;
        cpu_cenb <= 1'b0;
        forever begin
            @(posedge clk);
            cpu_cen  <= ~cpu_cen;
            cpu_cenb <= cpu_cen;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Memory map table
    function automatic main_pkg::sel_t exp_sel(input main_pkg::cpu_addr_t a);
        main_pkg::sel_t s;
        logic [4:0]     key;
        s   = '0;
        key = {a[23:22], a[18:16]};
        if (a[23:22] == main_pkg::PAGE_ROM) begin
            s[main_pkg::SEL_ROM] = 1'b1;    // Whole page whatever the sub-page
        end else begin
            case (key)
                {main_pkg::PAGE_VIDEO, main_pkg::SUB_VRAM}: s[main_pkg::SEL_VRAM] = 1'b1;
                {main_pkg::PAGE_VIDEO, main_pkg::SUB_CHAR}: s[main_pkg::SEL_CHAR] = 1'b1;
                {main_pkg::PAGE_VIDEO, main_pkg::SUB_OBJ}:  s[main_pkg::SEL_OBJ]  = 1'b1;
                {main_pkg::PAGE_PAL,   main_pkg::SUB_PAL}:  s[main_pkg::SEL_PAL]  = 1'b1;
                {main_pkg::PAGE_SYS,   main_pkg::SUB_IO}:   s[main_pkg::SEL_IO]   = 1'b1;
                {main_pkg::PAGE_SYS,   main_pkg::SUB_WDOG}: s[main_pkg::SEL_WDOG] = 1'b1;
                {main_pkg::PAGE_SYS,   main_pkg::SUB_RAM}:  s[main_pkg::SEL_RAM]  = 1'b1;
                default: s = '0;
            endcase
        end
        return s;
    endfunction

    function automatic main_pkg::word_t exp_din(
        input main_pkg::sel_t  s,
        input main_pkg::word_t ram,
        input main_pkg::word_t rom,
        input main_pkg::word_t chr,
        input main_pkg::word_t pal,
        input main_pkg::word_t obj
    );
        if (s[main_pkg::SEL_RAM] || s[main_pkg::SEL_VRAM]) return ram;
        if (s[main_pkg::SEL_ROM]) return rom;
        if (s[main_pkg::SEL_CHAR]) return chr;
        if (s[main_pkg::SEL_PAL]) return pal;
        if (s[main_pkg::SEL_OBJ]) return obj;
        return main_pkg::OPEN_BUS;
    endfunction

    function automatic logic exp_irq_line(input logic [LINE_W-1:0] line);
        return line == LINE_W'(VBLANK_LINE);
    endfunction

    // Active-low write strobe for one byte lane
    function automatic logic exp_wstrobe(input logic rd, input logic strobe_n);
        return !(rd == 1'b0 && strobe_n == 1'b0);
    endfunction

    function automatic logic exp_vpa(input logic [2:0] code, input logic strobe_n);
        return !(code == 3'b111 && strobe_n == 1'b0);
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check_sel(input string name, input main_pkg::sel_t got,
                             input main_pkg::sel_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input main_pkg::word_t got,
                              input main_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_rom_addr(input string name, input main_pkg::rom_addr_t got,
                                  input main_pkg::rom_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Combinational outputs on every falling edge
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            check_bit("uds_wn", uds_wn, exp_wstrobe(rnw, uds_n));
            check_bit("lds_wn", lds_wn, exp_wstrobe(rnw, lds_n));
            check_bit("vpa_n", vpa_n, exp_vpa(fc, as_n));
        end
    end

    task automatic wait_dtack_low(input int limit);
        int n;
        n = 0;
        while (dtack_n !== 1'b0) begin
            if (n == limit) begin
                abort_run("dtack_n stayed high after the device was ready");
            end
            @(negedge clk);
            n++;
        end
    endtask

    // One CPU read cycle with optional memory wait states
    task automatic bus_cycle(input main_pkg::cpu_addr_t a);
        main_pkg::sel_t s;
        logic           slow;
        int             wait_n;
        s      = exp_sel(a);
        slow   = s[main_pkg::SEL_ROM] | s[main_pkg::SEL_RAM] | s[main_pkg::SEL_VRAM];
        rng    = xorshift32(rng);
        wait_n = slow ? int'(rng[2:0]) : 0;
        @(posedge clk);
        addr      <= a;
        as_n      <= 1'b0;
        // Only the selected memory stalls
        rom_ok    <= s[main_pkg::SEL_ROM] ? (wait_n == 0) : rng[3];
        ram_ok    <= (s[main_pkg::SEL_RAM] | s[main_pkg::SEL_VRAM]) ? (wait_n == 0) : rng[4];
        rom_data  <= rng[31:16];
        ram_data  <= rng[15:0];
        char_dout <= rng[23:8];
        pal_dout  <= ~rng[31:16];
        obj_dout  <= ~rng[15:0];
        @(posedge clk);
        @(negedge clk);
        check_sel("sel", dut_sel, s);
        if (s[main_pkg::SEL_ROM]) begin
            exp_rom = a[17:1];
        end
        check_rom_addr("rom_addr", rom_addr, exp_rom);
        @(posedge clk);
        @(negedge clk);
        check_word("cpu_din", cpu_din,
                   exp_din(s, ram_data, rom_data, char_dout, pal_dout, obj_dout));
        repeat (wait_n) begin
            check_bit("dtack_n", dtack_n, 1'b1);
            @(negedge clk);
        end
        if (slow) begin
            @(posedge clk);
            rom_ok <= 1'b1;
            ram_ok <= 1'b1;
            @(negedge clk);
            wait_dtack_low(3);
        end else begin
            wait_dtack_low(2);      // Four clocks from the strobe
        end
        @(posedge clk);
        as_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit("dtack_n", dtack_n, 1'b1);
        check_sel("sel", dut_sel, '0);
    endtask

    // No selects while the strobe is high or the bus is granted away
    task automatic gated_decode;
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            @(posedge clk);
            addr    <= rng[22:0];
            as_n    <= i[0];
            bgack_n <= i[0];
            @(posedge clk);
            @(negedge clk);
            check_sel("sel", dut_sel, '0);
            check_rom_addr("rom_addr", rom_addr, exp_rom);
        end
        @(posedge clk);
        as_n    <= 1'b1;
        bgack_n <= 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic strobe_walk;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            rnw   <= i[2];
            uds_n <= i[1];
            lds_n <= i[0];
            @(negedge clk);
            check_bit("uds_wn", uds_wn, exp_wstrobe(i[2], i[1]));
            check_bit("lds_wn", lds_wn, exp_wstrobe(i[2], i[0]));
        end
        @(posedge clk);
        rnw <= 1'b1;
    endtask

    task automatic hstart_edge(input logic [LINE_W-1:0] line, input logic exp_ipl);
        @(posedge clk);
        vdump  <= line;
        hstart <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit("ipl2_n", ipl2_n, exp_ipl);
        @(posedge clk);
        hstart <= 1'b0;
    endtask

    task automatic irq_test;
        logic [LINE_W-1:0] line;
        logic              ipl;
        ipl = 1'b1;
        for (int i = 0; i < 8; i++) begin
            rng  = xorshift32(rng);
            line = (i == 4) ? LINE_W'(VBLANK_LINE) : rng[LINE_W-1:0];
            if (exp_irq_line(line)) begin
                ipl = 1'b0;
            end
            hstart_edge(line, ipl);
        end
        // Autovector ack with a new request in the same clock
        @(posedge clk);
        addr   <= 23'h400000;       // Empty sub-page 0 of the palette page
        fc     <= 3'b111;
        as_n   <= 1'b0;
        vdump  <= LINE_W'(VBLANK_LINE);
        hstart <= 1'b1;
        @(negedge clk);
        check_bit("vpa_n", vpa_n, 1'b0);
        check_bit("ipl2_n", ipl2_n, 1'b0);
        @(posedge clk);
        @(negedge clk);
        check_bit("ipl2_n", ipl2_n, 1'b1);
        @(posedge clk);
        as_n   <= 1'b1;
        fc     <= 3'd0;
        hstart <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    initial begin
        main_pkg::cpu_addr_t a;
        rng       = 32'd30094;
        exp_rom   = '0;
        rst       <= 1'b1;
        addr      <= '0;
        as_n      <= 1'b1;
        rnw       <= 1'b1;
        uds_n     <= 1'b1;
        lds_n     <= 1'b1;
        bgack_n   <= 1'b1;
        fc        <= 3'd0;
        vdump     <= '0;
        hstart    <= 1'b0;
        rom_data  <= '0;
        ram_data  <= '0;
        char_dout <= '0;
        pal_dout  <= '0;
        obj_dout  <= '0;
        rom_ok    <= 1'b1;
        ram_ok    <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_sel("sel", dut_sel, '0);
        check_rom_addr("rom_addr", rom_addr, '0);
        check_word("cpu_din", cpu_din, main_pkg::OPEN_BUS);
        check_bit("dtack_n", dtack_n, 1'b1);
        check_bit("ipl2_n", ipl2_n, 1'b1);
        for (int k = 0; k < N_SWEEP; k++) begin
            rng      = xorshift32(rng);
            a        = rng[22:0];
            a[23:22] = k[4:3];
            a[18:16] = k[2:0];
            bus_cycle(a);
        end
        for (int k = 0; k < N_RANDOM; k++) begin
            rng = xorshift32(rng);
            bus_cycle(rng[22:0]);
        end
        gated_decode;
        strobe_walk;
        irq_test;
        $display("all tests passed");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CLKS) @(posedge clk);
        abort_run("watchdog expired, the run hung");
    end

endmodule

/* source/addr_decoder.sv */
`timescale 1ns/100ps

module addr_decoder (
    input  logic                 clk,
    input  logic                 rst,
    cpu_bus_if.decode            bus,
    output main_pkg::sel_t       sel,
    output main_pkg::rom_addr_t  rom_addr,
    output logic                 uds_wn,
    output logic                 lds_wn
);

    main_pkg::page_t    page;
    main_pkg::subpage_t sub;
    main_pkg::sel_t     sel_d;
    logic               cycle_on;

    assign page     = bus.addr[23:22];
    assign sub      = bus.addr[18:16];
    assign cycle_on = !bus.as_n && bus.bgack_n;     // Our CPU owns an active cycle

    // Write strobes, low only on a write with the byte lane enabled
    assign uds_wn = bus.rnw | bus.uds_n;
    assign lds_wn = bus.rnw | bus.lds_n;

    always_comb begin
        sel_d = '0;
        if (cycle_on) begin
            sel_d[main_pkg::SEL_ROM]  = page == main_pkg::PAGE_ROM;
            sel_d[main_pkg::SEL_VRAM] = page == main_pkg::PAGE_VIDEO &&
                                        sub == main_pkg::SUB_VRAM;
            sel_d[main_pkg::SEL_CHAR] = page == main_pkg::PAGE_VIDEO &&
                                        sub == main_pkg::SUB_CHAR;
            sel_d[main_pkg::SEL_OBJ]  = page == main_pkg::PAGE_VIDEO &&
                                        sub == main_pkg::SUB_OBJ;
            sel_d[main_pkg::SEL_PAL]  = page == main_pkg::PAGE_PAL &&
                                        sub == main_pkg::SUB_PAL;
            // System page holds I/O, watchdog and work RAM
            sel_d[main_pkg::SEL_IO]   = page == main_pkg::PAGE_SYS &&
                                        sub == main_pkg::SUB_IO;
            sel_d[main_pkg::SEL_WDOG] = page == main_pkg::PAGE_SYS &&
                                        sub == main_pkg::SUB_WDOG;
            sel_d[main_pkg::SEL_RAM]  = page == main_pkg::PAGE_SYS &&
                                        sub == main_pkg::SUB_RAM;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else begin
            sel <= sel_d;   // Drops to zero as soon as the strobe is seen high
        end
    end

    // ROM address is kept between ROM cycles for the SDRAM controller
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_addr <= '0;
        end else if (cycle_on && page == main_pkg::PAGE_ROM) begin
            rom_addr <= bus.addr[17:1];
        end
    end

endmodule

/* source/cpu_bus_if.sv */
`timescale 1ns/100ps

interface cpu_bus_if;

    main_pkg::cpu_addr_t addr;
    logic                as_n;      // Address strobe
    logic                rnw;
    logic                uds_n;
    logic                lds_n;
    logic [2:0]          fc;        // Function code, all ones on interrupt ack
    logic                bgack_n;   // Another master owns the bus when low

    // Memory map decoding
    modport decode (
        input addr,
        input as_n,
        input rnw,
        input uds_n,
        input lds_n,
        input bgack_n
    );

    // Data acknowledge only follows the strobe
    modport ack (
        input as_n
    );

    // Autovector interrupt acknowledge
    modport irq (
        input as_n,
        input fc
    );

endinterface

/* source/dtack_gen.sv */
`timescale 1ns/100ps

module dtack_gen (
    input  logic           clk,
    input  logic           rst,
    input  logic           cpu_cen,
    input  logic           cpu_cenb,
    cpu_bus_if.ack         bus,
    input  main_pkg::sel_t sel,
    input  logic           rom_ok,
    input  logic           ram_ok,
    output logic           dtack_n
);

    typedef enum logic [1:0] {IDLE, WAIT, ACK} state_t;

    state_t state;
    logic   bus_cs;
    logic   bus_busy;
    logic   ready;      // Select was up and idle on the previous clock

    // Devices that answer with real data, I/O and watchdog excluded
    assign bus_cs = sel[main_pkg::SEL_ROM]  | sel[main_pkg::SEL_VRAM] |
                    sel[main_pkg::SEL_CHAR] | sel[main_pkg::SEL_OBJ]  |
                    sel[main_pkg::SEL_PAL]  | sel[main_pkg::SEL_RAM];

    assign bus_busy = (sel[main_pkg::SEL_ROM] & ~rom_ok) |
                      ((sel[main_pkg::SEL_RAM] | sel[main_pkg::SEL_VRAM]) & ~ram_ok);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            ready   <= 1'b0;
            dtack_n <= 1'b1;
        end else begin
            ready <= bus_cs & ~bus_busy;
            case (state)
                IDLE: begin
                    dtack_n <= 1'b1;
                    if (!bus.as_n) state <= WAIT;  // Selects settle on the next clock
                end
                WAIT: begin
                    if (bus.as_n) begin
                        if (cpu_cen) state <= IDLE;    // Aborted cycle
                    end else if (cpu_cenb && (!bus_cs || (ready && !bus_busy))) begin
                        dtack_n <= 1'b0;
                        state   <= ACK;
                    end
                end
                ACK: begin
                    if (bus.as_n) begin
                        dtack_n <= 1'b1;
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* source/main_glue.sv */
`timescale 1ns/100ps

module main_glue #(
    parameter int LINE_W      = 9,
    parameter int VBLANK_LINE = 223
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_cen,
    input  logic                cpu_cenb,
    input  main_pkg::cpu_addr_t addr,
    input  logic                as_n,
    input  logic                rnw,
    input  logic                uds_n,
    input  logic                lds_n,
    input  logic                bgack_n,
    input  logic [2:0]          fc,
    output main_pkg::word_t     cpu_din,
    output logic                dtack_n,
    output logic                ipl2_n,
    output logic                vpa_n,
    output logic                uds_wn,
    output logic                lds_wn,
    input  logic [LINE_W-1:0]   vdump,
    input  logic                hstart,
    output logic                rom_cs,
    output logic                vram_cs,
    output logic                char_cs,
    output logic                objram_cs,
    output logic                pal_cs,
    output logic                io_cs,
    output logic                wdog_cs,
    output logic                ram_cs,
    output main_pkg::rom_addr_t rom_addr,
    input  main_pkg::word_t     rom_data,
    input  main_pkg::word_t     ram_data,
    input  main_pkg::word_t     char_dout,
    input  main_pkg::word_t     pal_dout,
    input  main_pkg::word_t     obj_dout,
    input  logic                rom_ok,
    input  logic                ram_ok
);

    main_pkg::sel_t sel;

    cpu_bus_if bus ();

    assign bus.addr    = addr;
    assign bus.as_n    = as_n;
    assign bus.rnw     = rnw;
    assign bus.uds_n   = uds_n;
    assign bus.lds_n   = lds_n;
    assign bus.fc      = fc;
    assign bus.bgack_n = bgack_n;

    // Named chip selects for the board
    assign rom_cs    = sel[main_pkg::SEL_ROM];
    assign vram_cs   = sel[main_pkg::SEL_VRAM];
    assign char_cs   = sel[main_pkg::SEL_CHAR];
    assign objram_cs = sel[main_pkg::SEL_OBJ];
    assign pal_cs    = sel[main_pkg::SEL_PAL];
    assign io_cs     = sel[main_pkg::SEL_IO];
    assign wdog_cs   = sel[main_pkg::SEL_WDOG];
    assign ram_cs    = sel[main_pkg::SEL_RAM];

    addr_decoder u_decoder (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus.decode),
        .sel      (sel),
        .rom_addr (rom_addr),
        .uds_wn   (uds_wn),
        .lds_wn   (lds_wn)
    );

    read_mux u_mux (
        .clk       (clk),
        .rst       (rst),
        .sel       (sel),
        .ram_data  (ram_data),
        .rom_data  (rom_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cpu_din   (cpu_din)
    );

    dtack_gen u_dtack (
        .clk      (clk),
        .rst      (rst),
        .cpu_cen  (cpu_cen),
        .cpu_cenb (cpu_cenb),
        .bus      (bus.ack),
        .sel      (sel),
        .rom_ok   (rom_ok),
        .ram_ok   (ram_ok),
        .dtack_n  (dtack_n)
    );

    vblank_irq #(
        .LINE_W      (LINE_W),
        .VBLANK_LINE (VBLANK_LINE)
    ) u_irq (
        .clk    (clk),
        .rst    (rst),
        .vdump  (vdump),
        .hstart (hstart),
        .bus    (bus.irq),
        .ipl2_n (ipl2_n),
        .vpa_n  (vpa_n)
    );

endmodule

/* source/main_pkg.sv */
package main_pkg;

    // Bus widths
    typedef logic [23:1] cpu_addr_t;    // 68000 word address, A0 is implied by the strobes
    typedef logic [15:0] word_t;
    typedef logic [17:1] rom_addr_t;    // 256 kB of program ROM
    typedef logic [7:0]  sel_t;         // One chip select per device

    // Address fields used by the memory map
    typedef logic [1:0]  page_t;        // A23..A22
    typedef logic [2:0]  subpage_t;     // A18..A16

    // Bit positions inside sel_t
    localparam int SEL_ROM  = 0;
    localparam int SEL_VRAM = 1;
    localparam int SEL_CHAR = 2;
    localparam int SEL_OBJ  = 3;
    localparam int SEL_PAL  = 4;
    localparam int SEL_IO   = 5;
    localparam int SEL_WDOG = 6;
    localparam int SEL_RAM  = 7;

    // Pages
    localparam page_t PAGE_ROM   = 2'd0;    // 00-3f
    localparam page_t PAGE_VIDEO = 2'd1;    // 40-7f
    localparam page_t PAGE_PAL   = 2'd2;    // 80-bf
    localparam page_t PAGE_SYS   = 2'd3;    // c0-ff

    // Sub-pages within a page
    localparam subpage_t SUB_VRAM = 3'd0;   // 40
    localparam subpage_t SUB_CHAR = 3'd1;   // 41
    localparam subpage_t SUB_OBJ  = 3'd4;   // 44
    localparam subpage_t SUB_PAL  = 3'd4;   // 84
    localparam subpage_t SUB_IO   = 3'd4;   // c4
    localparam subpage_t SUB_WDOG = 3'd6;   // c6
    localparam subpage_t SUB_RAM  = 3'd7;   // c7

    // Pulled-up data bus when nobody drives it
    localparam word_t OPEN_BUS = 16'hffff;

endpackage

/* source/read_mux.sv */
`timescale 1ns/100ps

module read_mux (
    input  logic            clk,
    input  logic            rst,
    input  main_pkg::sel_t  sel,
    input  main_pkg::word_t ram_data,   // Shared by work RAM and VRAM
    input  main_pkg::word_t rom_data,
    input  main_pkg::word_t char_dout,
    input  main_pkg::word_t pal_dout,
    input  main_pkg::word_t obj_dout,
    output main_pkg::word_t cpu_din
);

    logic ram_rd;

    assign ram_rd = sel[main_pkg::SEL_RAM] | sel[main_pkg::SEL_VRAM];

    // Priority order matters only if two selects ever overlap
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cpu_din <= main_pkg::OPEN_BUS;
        end else begin
            if (ram_rd) begin
                cpu_din <= ram_data;
            end else if (sel[main_pkg::SEL_ROM]) begin
                cpu_din <= rom_data;
            end else if (sel[main_pkg::SEL_CHAR]) begin
                cpu_din <= char_dout;
            end else if (sel[main_pkg::SEL_PAL]) begin
                cpu_din <= pal_dout;
            end else if (sel[main_pkg::SEL_OBJ]) begin
                cpu_din <= obj_dout;
            end else begin
                cpu_din <= main_pkg::OPEN_BUS;     // I/O, watchdog, unmapped
            end
        end
    end

endmodule

/* source/vblank_irq.sv */
`timescale 1ns/100ps

module vblank_irq #(
    parameter int LINE_W      = 9,
    parameter int VBLANK_LINE = 223
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [LINE_W-1:0] vdump,
    input  logic              hstart,
    cpu_bus_if.irq            bus,
    output logic              ipl2_n,
    output logic              vpa_n
);

    logic last_hstart;
    logic inta;
    logic line_start;

    // Autovector acknowledge, FC=7 with the strobe down
    assign inta  = &bus.fc & ~bus.as_n;
    assign vpa_n = ~inta;

    assign line_start = hstart & ~last_hstart;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            last_hstart <= 1'b0;
            ipl2_n      <= 1'b1;
        end else begin
            last_hstart <= hstart;
            if (inta) begin
                ipl2_n <= 1'b1;     // Ack wins over a request in the same clock
            end else if (line_start && vdump == LINE_W'(VBLANK_LINE)) begin
                ipl2_n <= 1'b0;
            end
        end
    end

endmodule
